// ==== src/p4_router_pkg.sv ====
// port and metadata layouts follow the match-action engine build
// port ids pass through unmapped, so widths must agree on both sides
package p4_router_pkg;

    ////////////////////////////////////////////////////////////
    // scalar fields
    ////////////////////////////////////////////////////////////

    // router port index
    typedef logic [3:0] port_id_t;

    // frame length in bytes, whole frame
    typedef logic [15:0] byte_len_t;

    ////////////////////////////////////////////////////////////
    // sideband and engine metadata
    ////////////////////////////////////////////////////////////

    // ingress stream tuser, valid on every beat
    typedef struct packed {
        port_id_t  ingress_port;
        byte_len_t byte_length;
    } ingress_meta_t;

    // engine user metadata, same layout in and out
    typedef struct packed {
        logic [7:0]  drop_reason;
        logic [15:0] ether_type;
        logic [19:0] mpls_label;
        logic [11:0] vlan_id;
        logic [7:0]  vrf_id;
        logic        bos;
        port_id_t    ingress_port;
        port_id_t    egress_port;
        byte_len_t   byte_length;
    } p4_user_meta_t;

    // egress stream tuser
    typedef struct packed {
        port_id_t   ingress_port;
        port_id_t   egress_port;
        logic [2:0] prio;
        byte_len_t  byte_length;
    } egress_meta_t;

    // position within the ingress frame
    typedef enum logic {
        idle_frame,
        in_frame
    } frame_state_t;

endpackage

// ==== src/ipv4_csum_pkg.sv ====
// options are not supported, the header is always the fixed 20 bytes
// extern valid bits are single-cycle strobes, no back-pressure
package ipv4_csum_pkg;

    ////////////////////////////////////////////////////////////
    // ipv4 header geometry
    ////////////////////////////////////////////////////////////

    localparam int IPV4_HDR_BYTES = 20;
    // 16-bit words covered by the checksum
    localparam int IPV4_HDR_WORDS = IPV4_HDR_BYTES / 2;

    // first header byte sits in the top bits
    typedef logic [8*IPV4_HDR_BYTES-1:0] ipv4_hdr_t;

    typedef logic [15:0] csum_t;
    typedef logic [7:0]  ttl_t;

    ////////////////////////////////////////////////////////////
    // extern request and response
    ////////////////////////////////////////////////////////////

    // checksum update after ttl decrement
    typedef struct packed {
        csum_t hdr_chk;
        ttl_t  old_ttl;
        ttl_t  new_ttl;
    } csum_update_req_t;

    // engine to shell
    typedef struct packed {
        ipv4_hdr_t        verify_hdr;
        csum_update_req_t update;
    } extern_req_t;

    // shell to engine
    typedef struct packed {
        logic  verify_ok;
        csum_t update_chk;
    } extern_rsp_t;

    // one strobe per extern, same layout both directions
    typedef struct packed {
        logic verify;
        logic update;
    } extern_valid_t;

endpackage

// ==== src/p4_metadata_mapper.sv ====
// assumes tuser is stable across a frame, only the first beat is used
// port ids are copied straight through, no remapping table
module p4_metadata_mapper (
    input  logic                        packet_data_in,
    input  logic                        rst_n,
    input  logic                        ingress_valid,
    input  logic                        ingress_ready,
    input  logic                        ingress_last,
    input  p4_router_pkg::ingress_meta_t ingress_tuser,
    input  p4_router_pkg::p4_user_meta_t meta_out,
    input  logic                        meta_out_valid,
    output p4_router_pkg::p4_user_meta_t meta_in,
    output logic                        meta_in_valid,
    output p4_router_pkg::egress_meta_t egress_tuser
);

    import p4_router_pkg::*;

    frame_state_t  frame_state;
    logic          beat;
    logic          sof;
    p4_user_meta_t meta_in_next;
    egress_meta_t  egress_next;

    ////////////////////////////////////////////////////////////
    // frame tracking
    ////////////////////////////////////////////////////////////

    // handshake beat, ready alone is the only stall
    assign beat = ingress_valid && ingress_ready;
    // first counted beat, one-beat frames included
    assign sof  = beat && (frame_state == idle_frame);

    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            frame_state <= idle_frame;
        end else if (beat) begin
            // last beat closes the frame whatever the state
            frame_state <= ingress_last ? idle_frame : in_frame;
        end
    end

    ////////////////////////////////////////////////////////////
    // ingress metadata to engine
    ////////////////////////////////////////////////////////////

    always_comb begin
        meta_in_next              = '0;
        // only port and length are known at ingress
        meta_in_next.ingress_port = ingress_tuser.ingress_port;
        meta_in_next.byte_length  = ingress_tuser.byte_length;
    end

    // data loads on sof only
    always_ff @(posedge packet_data_in) begin
        if (sof) begin
            meta_in <= meta_in_next;
        end
    end

    // one-cycle pulse after the first beat
    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            meta_in_valid <= 1'b0;
        end else begin
            meta_in_valid <= sof;
        end
    end

    ////////////////////////////////////////////////////////////
    // engine metadata to egress sideband
    ////////////////////////////////////////////////////////////

    always_comb begin
        egress_next.ingress_port = meta_out.ingress_port;
        egress_next.egress_port  = meta_out.egress_port;
        // no priority classes yet
        egress_next.prio         = '0;
        egress_next.byte_length  = meta_out.byte_length;
    end

    // held until the next engine strobe
    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            egress_tuser <= '0;
        end else if (meta_out_valid) begin
            egress_tuser <= egress_next;
        end
    end

endmodule

// ==== src/ipv4_csum_verify.sv ====
// fixed 2-cycle latency, accepts a header every cycle
// the checksum field is summed with the rest, a good header folds to ffff
module ipv4_csum_verify (
    input  logic                   packet_data_in,
    input  logic                   rst_n,
    input  ipv4_csum_pkg::ipv4_hdr_t hdr,
    input  logic                   hdr_valid,
    output logic                   hdr_ok,
    output logic                   hdr_ok_valid
);

    import ipv4_csum_pkg::*;

    // words per half of the adder tree
    localparam int HALF_WORDS = IPV4_HDR_WORDS / 2;
    // five 16-bit words need 3 carry bits
    localparam int HALF_BITS  = 19;

    logic [HALF_BITS-1:0] sum_lo;
    logic [HALF_BITS-1:0] sum_hi;
    logic [HALF_BITS-1:0] sum_lo_q;
    logic [HALF_BITS-1:0] sum_hi_q;
    logic                 s1_valid;
    logic [HALF_BITS:0]   sum_all;
    logic [16:0]          fold_1;
    csum_t                fold_2;

    ////////////////////////////////////////////////////////////
    // stage one, two partial sums
    ////////////////////////////////////////////////////////////

    always_comb begin
        sum_lo = '0;
        sum_hi = '0;
        // word 0 of the header sits in the top bits
        for (int i = 0; i < HALF_WORDS; i++) begin
            sum_lo = sum_lo + HALF_BITS'(hdr[16*i +: 16]);
            sum_hi = sum_hi + HALF_BITS'(hdr[16*(i+HALF_WORDS) +: 16]);
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (hdr_valid) begin
            sum_lo_q <= sum_lo;
            sum_hi_q <= sum_hi;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage two, join and fold
    ////////////////////////////////////////////////////////////

    assign sum_all = sum_lo_q + sum_hi_q;
    // end-around carry, second pass catches the carry of the first
    assign fold_1  = sum_all[15:0] + 17'(sum_all[HALF_BITS:16]);
    assign fold_2  = fold_1[15:0] + 16'(fold_1[16]);

    // result holds between requests
    always_ff @(posedge packet_data_in) begin
        if (s1_valid) begin
            hdr_ok <= (fold_2 == 16'hffff);
        end
    end

    // valid pipe
    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            hdr_ok_valid <= 1'b0;
        end else begin
            s1_valid     <= hdr_valid;
            hdr_ok_valid <= s1_valid;
        end
    end

endmodule

// ==== src/ipv4_csum_update.sv ====
// fixed 2-cycle latency and one request per cycle
// ttl is taken as a zero-extended word and not paired with the protocol byte
module ipv4_csum_update (
    input  logic                          packet_data_in,
    input  logic                          rst_n,
    input  ipv4_csum_pkg::csum_update_req_t req,
    input  logic                          req_valid,
    output ipv4_csum_pkg::csum_t          new_chk,
    output logic                          new_chk_valid
);

    import ipv4_csum_pkg::*;

    csum_t       old_ttl_word;
    csum_t       new_ttl_word;
    logic [31:0] term_sum;
    logic [31:0] term_sum_q;
    logic        s1_valid;
    logic [16:0] fold_1;
    csum_t       fold_2;

    ////////////////////////////////////////////////////////////
    // stage one sums the three terms
    ////////////////////////////////////////////////////////////

    assign old_ttl_word = {8'h00, req.old_ttl};
    assign new_ttl_word = {8'h00, req.new_ttl};

    // ~hc + ~m + m' with carries kept for the fold
    // each term complemented at 16 bits before widening
    assign term_sum = {16'h0, ~req.hdr_chk} + {16'h0, ~old_ttl_word} + {16'h0, new_ttl_word};

    always_ff @(posedge packet_data_in) begin
        if (req_valid) begin
            term_sum_q <= term_sum;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage two folds twice and complements
    ////////////////////////////////////////////////////////////

    assign fold_1 = 17'(term_sum_q[15:0]) + 17'(term_sum_q[31:16]);
    assign fold_2 = fold_1[15:0] + 16'(fold_1[16]);

    // checksum holds until the next request completes
    always_ff @(posedge packet_data_in) begin
        if (s1_valid) begin
            new_chk <= ~fold_2;
        end
    end

    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid      <= 1'b0;
            new_chk_valid <= 1'b0;
        end else begin
            s1_valid      <= req_valid;
            new_chk_valid <= s1_valid;
        end
    end

endmodule

// ==== src/p4_extern_shell.sv ====
// faces the engine ports directly, the engine itself is not included
// extern responses come back a fixed 2 cycles after each request
module p4_extern_shell (
    input  logic                         packet_data_in,
    input  logic                         rst_n,
    input  logic                         ingress_valid,
    input  logic                         ingress_ready,
    input  logic                         ingress_last,
    input  p4_router_pkg::ingress_meta_t ingress_tuser,
    input  p4_router_pkg::p4_user_meta_t meta_out,
    input  logic                         meta_out_valid,
    input  ipv4_csum_pkg::extern_req_t   ext_req,
    input  ipv4_csum_pkg::extern_valid_t ext_req_valid,
    output p4_router_pkg::p4_user_meta_t meta_in,
    output logic                         meta_in_valid,
    output p4_router_pkg::egress_meta_t  egress_tuser,
    output ipv4_csum_pkg::extern_rsp_t   ext_rsp,
    output ipv4_csum_pkg::extern_valid_t ext_rsp_valid
);

    import ipv4_csum_pkg::*;

    logic  verify_ok;
    logic  verify_valid;
    csum_t update_chk;
    logic  update_valid;

    ////////////////////////////////////////////////////////////
    // metadata path
    ////////////////////////////////////////////////////////////

    p4_metadata_mapper i_p4_metadata_mapper (
        .packet_data_in ( packet_data_in ),
        .rst_n          ( rst_n          ),
        .ingress_valid  ( ingress_valid  ),
        .ingress_ready  ( ingress_ready  ),
        .ingress_last   ( ingress_last   ),
        .ingress_tuser  ( ingress_tuser  ),
        .meta_out       ( meta_out       ),
        .meta_out_valid ( meta_out_valid ),
        .meta_in        ( meta_in        ),
        .meta_in_valid  ( meta_in_valid  ),
        .egress_tuser   ( egress_tuser   )
    );

    ////////////////////////////////////////////////////////////
    // checksum externs, independent of each other
    ////////////////////////////////////////////////////////////

    ipv4_csum_verify i_ipv4_csum_verify (
        .packet_data_in ( packet_data_in       ),
        .rst_n          ( rst_n                ),
        .hdr            ( ext_req.verify_hdr   ),
        .hdr_valid      ( ext_req_valid.verify ),
        .hdr_ok         ( verify_ok            ),
        .hdr_ok_valid   ( verify_valid         )
    );

    ipv4_csum_update i_ipv4_csum_update (
        .packet_data_in ( packet_data_in       ),
        .rst_n          ( rst_n                ),
        .req            ( ext_req.update       ),
        .req_valid      ( ext_req_valid.update ),
        .new_chk        ( update_chk           ),
        .new_chk_valid  ( update_valid         )
    );

    // join the two responses back into the engine layout
    assign ext_rsp       = '{verify_ok: verify_ok, update_chk: update_chk};
    assign ext_rsp_valid = '{verify: verify_valid, update: update_valid};

endmodule

// ==== verif/tb_p4_extern_shell.sv ====
// random stimulus every cycle, all checking done by concurrent assertions
// expected values come from the frame rules and the ipv4 checksum rules
module tb_p4_extern_shell;
    timeunit 1ns;
    timeprecision 1ps;

    import p4_router_pkg::*;
    import ipv4_csum_pkg::*;

    localparam int STIM_CYCLES = 600;
    // one beat and two requests at most per cycle
    localparam int MAX_EVENTS  = 3 * STIM_CYCLES;
    localparam int TIMEOUT_NS  = (MAX_EVENTS + 100) * 8;
    // checksum field, header bytes 10 and 11
    localparam int CSUM_LSB    = 64;

    logic          packet_data_in = 1'b0;
    logic          rst_n;
    logic          ingress_valid;
    logic          ingress_ready;
    logic          ingress_last;
    ingress_meta_t ingress_tuser;
    p4_user_meta_t meta_out;
    logic          meta_out_valid;
    extern_req_t   ext_req;
    extern_valid_t ext_req_valid;
    p4_user_meta_t meta_in;
    logic          meta_in_valid;
    egress_meta_t  egress_tuser;
    extern_rsp_t   ext_rsp;
    extern_valid_t ext_rsp_valid;

    // model state and expected-value pipes
    logic [31:0]   lfsr_state = 32'h2d71;
    int            errors;
    int            n_frames;
    int            n_verify;
    int            n_update;
    int            beats_left;
    frame_state_t  tb_state;
    logic          tb_sof;
    logic          sof_q;
    logic          egress_q;
    p4_user_meta_t exp_meta_q;
    egress_meta_t  exp_egress_q;
    extern_valid_t vld_d1, vld_d2;
    logic          exp_ok, ok_d1, ok_d2;
    csum_t         exp_chk, chk_d1, chk_d2;

    p4_extern_shell i_p4_extern_shell (.*);

    always #4 packet_data_in = ~packet_data_in;

    ////////////////////////////////////////////////////////////
    // random source and reference models
    ////////////////////////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // ones'-complement sum of the ten header words, fully folded
    function automatic csum_t ones_sum(input ipv4_hdr_t hdr);
        logic [31:0] acc;
        acc = '0;
        for (int w = 0; w < IPV4_HDR_WORDS; w++) begin
            acc = acc + {16'h0, hdr[16*w +: 16]};
        end
        while (acc[31:16] != 16'h0) begin
            acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        end
        return acc[15:0];
    endfunction

    // HC' = ~(~HC + ~m + m'), m is the zero-extended ttl
    function automatic csum_t ttl_update_model(input csum_update_req_t r);
        logic [31:0] acc;
        acc = {16'h0, ~r.hdr_chk} + {16'h0, 8'hff, ~r.old_ttl} + {24'h0, r.new_ttl};
        while (acc[31:16] != 16'h0) begin
            acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        end
        return ~acc[15:0];
    endfunction

    // good checksum first, then maybe one flipped bit
    function automatic ipv4_hdr_t random_header(input logic corrupt);
        ipv4_hdr_t hdr;
        int        flip;
        hdr = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        hdr[CSUM_LSB +: 16] = '0;
        hdr[CSUM_LSB +: 16] = ~ones_sum(hdr);
        if (corrupt) begin
            flip      = int'(rand_bits(8) % 160);
            hdr[flip] = ~hdr[flip];
        end
        return hdr;
    endfunction

    task automatic note_mismatch(input string name, input logic [191:0] exp_val,
                                 input logic [191:0] act_val);
        errors++;
        $display("error %s expected %0h got %0h", name, exp_val, act_val);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    ////////////////////////////////////////////////////////////
    // frame model and expected-value pipes
    ////////////////////////////////////////////////////////////

    assign tb_sof = ingress_valid && ingress_ready && (tb_state == idle_frame);

    always @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            tb_state <= idle_frame;
            sof_q    <= 1'b0;
            egress_q <= 1'b0;
            vld_d1   <= '0;
            vld_d2   <= '0;
        end else begin
            if (ingress_valid && ingress_ready) begin
                tb_state <= ingress_last ? idle_frame : in_frame;
            end
            if (tb_sof) begin
                n_frames++;
                exp_meta_q <= '{ingress_port: ingress_tuser.ingress_port,
                                byte_length: ingress_tuser.byte_length, default: '0};
            end
            if (meta_out_valid) begin
                exp_egress_q <= '{ingress_port: meta_out.ingress_port,
                                  egress_port: meta_out.egress_port, prio: 3'b000,
                                  byte_length: meta_out.byte_length};
            end
            n_verify = n_verify + int'(ext_req_valid.verify);
            n_update = n_update + int'(ext_req_valid.update);
            sof_q    <= tb_sof;
            egress_q <= meta_out_valid;
            // responses are due two edges after the request
            vld_d1   <= ext_req_valid;
            vld_d2   <= vld_d1;
        end
        ok_d1  <= exp_ok;
        ok_d2  <= ok_d1;
        chk_d1 <= exp_chk;
        chk_d2 <= chk_d1;
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    reset_chk: assert property (@(posedge packet_data_in) (!rst_n || $rose(rst_n)) |->
        (!meta_in_valid && ext_rsp_valid == 2'b00 && egress_tuser == '0))
        else note_failure("outputs were not idle during or just after reset");
    sof_pulse_chk: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        meta_in_valid == sof_q)
        else note_mismatch("meta_in_valid", $sampled(sof_q), $sampled(meta_in_valid));
    meta_in_chk: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        sof_q |-> meta_in == exp_meta_q)
        else note_mismatch("meta_in", $sampled(exp_meta_q), $sampled(meta_in));
    egress_chk: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        egress_q |-> egress_tuser == exp_egress_q)
        else note_mismatch("egress_tuser", $sampled(exp_egress_q), $sampled(egress_tuser));
    egress_hold_chk: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        !egress_q |-> $stable(egress_tuser))
        else note_failure("egress_tuser changed without a meta_out_valid strobe");
    verify_time_chk: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        ext_rsp_valid.verify == vld_d2.verify)
        else note_failure("verify response strobe was not 2 cycles after its request");
    verify_ok_chk: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        vld_d2.verify |-> ext_rsp.verify_ok == ok_d2)
        else note_mismatch("ext_rsp.verify_ok", $sampled(ok_d2), $sampled(ext_rsp.verify_ok));
    update_time_chk: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        ext_rsp_valid.update == vld_d2.update)
        else note_failure("update response strobe was not 2 cycles after its request");
    update_chk_chk: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        vld_d2.update |-> ext_rsp.update_chk == chk_d2)
        else note_mismatch("ext_rsp.update_chk", $sampled(chk_d2), $sampled(ext_rsp.update_chk));

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n          = 1'b1;
        ingress_valid  = 1'b0;
        ingress_ready  = 1'b0;
        ingress_last   = 1'b0;
        ingress_tuser  = '0;
        meta_out       = '0;
        meta_out_valid = 1'b0;
        ext_req        = '0;
        ext_req_valid  = '0;
        exp_ok         = 1'b0;
        exp_chk        = '0;
        beats_left     = 0;
        #1 rst_n = 1'b0;
        repeat (3) @(posedge packet_data_in);
        #1 rst_n = 1'b1;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(posedge packet_data_in);
            #1;
            // last cycle's beat was taken if both were high
            if (ingress_valid && ingress_ready) begin
                beats_left--;
            end
            if (beats_left == 0) begin
                beats_left                 = int'(rand_bits(3) % 5) + 1;
                ingress_tuser.ingress_port = port_id_t'(rand_bits(4));
                ingress_tuser.byte_length  = byte_len_t'(rand_bits(16));
            end
            ingress_valid  = (rand_bits(2) != 0);
            ingress_ready  = (rand_bits(2) != 0);
            ingress_last   = (beats_left == 1);
            // engine output, random even without a strobe
            meta_out_valid           = (rand_bits(2) == 0);
            meta_out.drop_reason     = 8'(rand_bits(8));
            meta_out.vrf_id          = 8'(rand_bits(8));
            meta_out.ingress_port    = port_id_t'(rand_bits(4));
            meta_out.egress_port     = port_id_t'(rand_bits(4));
            meta_out.byte_length     = byte_len_t'(rand_bits(16));
            ext_req_valid.verify     = rand_bits(1) != 0;
            ext_req_valid.update     = rand_bits(1) != 0;
            if (ext_req_valid.verify) begin
                ext_req.verify_hdr = random_header(rand_bits(1) != 0);
                exp_ok             = (ones_sum(ext_req.verify_hdr) == 16'hffff);
            end
            if (ext_req_valid.update) begin
                ext_req.update.hdr_chk = (rand_bits(2) == 0) ? 16'hffff : csum_t'(rand_bits(16));
                ext_req.update.old_ttl = ttl_t'(rand_bits(8));
                // equal ttl now and then, the usual decrement otherwise
                ext_req.update.new_ttl = (rand_bits(2) == 0) ? ext_req.update.old_ttl :
                                         ext_req.update.old_ttl - 8'd1;
                exp_chk                = ttl_update_model(ext_req.update);
            end
        end
        @(posedge packet_data_in);
        #1;
        ingress_valid  = 1'b0;
        meta_out_valid = 1'b0;
        ext_req_valid  = '0;
        // drain the 2-cycle extern pipes
        repeat (3) @(posedge packet_data_in);
        #1;
        $display("frames %0d, verify %0d, update %0d, errors %0d",
                 n_frames, n_verify, n_update, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the stimulus finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
src/p4_router_pkg.sv
src/ipv4_csum_pkg.sv
src/p4_metadata_mapper.sv
src/ipv4_csum_verify.sv
src/ipv4_csum_update.sv
src/p4_extern_shell.sv
verif/tb_p4_extern_shell.sv
